/* include/lca_macros.svh */
`ifndef LCA_MACROS_SVH
`define LCA_MACROS_SVH

// number of logic blocks in the array
`define LCA_NUM_CLB 4

// configuration bits held by one block
`define LCA_CLB_CFG_W 36

// whole serial frame, all blocks back to back
`define LCA_FRAME_W 144

// wide enough to count every bit of the frame
`define LCA_CNT_W 8

`endif

/* design/lca_pkg.sv */
`default_nettype none

package lca_pkg;

   // how the 16-entry table is addressed
   typedef enum logic [1:0] {
      MODE_ONE4 = 2'd0, // one function of four inputs
      MODE_TWO3 = 2'd1, // two functions of three inputs
      MODE_BSEL = 2'd2  // b picks the table half
   } comb_mode_e;

   typedef enum logic [1:0] {
      ST_IDLE  = 2'd0,
      ST_SHIFT = 2'd1,
      ST_DONE  = 2'd2
   } cfg_state_e;

   // one block's configuration, msb first as it arrives on the serial port
   typedef struct packed {
      logic [15:0] lut;
      comb_mode_e  mode;
      logic [2:0]  in_sel_f; // bit 2 a/b, bit 1 b/c, bit 0 c/dq1
      logic [2:0]  in_sel_g;
      logic [1:0]  dq_sel;   // per bit, 0 takes d and 1 takes q
      logic [1:0]  s_sel;
      logic [1:0]  r_sel;
      logic [1:0]  ce_sel;
      logic [1:0]  x_sel;
      logic [1:0]  y_sel;
   } clb_cfg_t;

   typedef struct packed {
      logic a;
      logic b;
      logic c;
      logic k; // shared across all blocks
   } clb_pins_t;

endpackage

`default_nettype wire

/* design/cfg_loader_fsm.sv */
`timescale 1ns/1ps
`default_nettype none

module cfg_loader_fsm (
   input  wire  KLK,
   input  wire  rst_n,
   input  wire  cfg_start,
   input  wire  cfg_strobe,
   input  wire  cnt_last,
   output logic clr_cnt,
   output logic shift_en,
   output logic commit,
   output logic clear_active,
   output logic cfg_done
);

   lca_pkg::cfg_state_e state;
   lca_pkg::cfg_state_e state_nxt;

   // a start always wins, even over a strobe in the same cycle
   assign clr_cnt      = cfg_start;
   assign clear_active = cfg_start;
   assign shift_en     = cfg_strobe && !cfg_start && (state == lca_pkg::ST_SHIFT);
   assign commit       = shift_en && cnt_last; // the strobe carrying the final bit

   always_comb
   begin
      state_nxt = state;
      if (cfg_start)
      begin
         state_nxt = lca_pkg::ST_SHIFT;
      end
      else if (commit)
      begin
         state_nxt = lca_pkg::ST_DONE;
      end
   end

   always_ff @(posedge KLK or negedge rst_n)
   begin
      if (!rst_n)
      begin
         state    <= lca_pkg::ST_IDLE;
         cfg_done <= 1'b0;
      end
      else
      begin
         state    <= state_nxt;
         cfg_done <= (state_nxt == lca_pkg::ST_DONE); // tracks ST_DONE exactly
      end
   end

endmodule

`default_nettype wire

/* design/cfg_bit_counter.sv */
`timescale 1ns/1ps
`default_nettype none
`include "lca_macros.svh"

module cfg_bit_counter (
   input  wire  KLK,
   input  wire  rst_n,
   input  wire  clr_cnt,
   input  wire  shift_en,
   output logic cnt_last
);

   localparam logic [`LCA_CNT_W-1:0] LAST_CNT = `LCA_CNT_W'(`LCA_FRAME_W - 1);

   logic [`LCA_CNT_W-1:0] cnt;

   always_ff @(posedge KLK or negedge rst_n)
   begin
      if (!rst_n)
         cnt <= '0;
      else if (clr_cnt)
         cnt <= '0;
      else if (shift_en)
         cnt <= cnt + 1'b1;
   end

   // high while the next strobe is the last one of the frame
   assign cnt_last = (cnt == LAST_CNT);

endmodule

`default_nettype wire

/* design/cfg_frame.sv */
`timescale 1ns/1ps
`default_nettype none
`include "lca_macros.svh"

module cfg_frame (
   input  wire                                      KLK,
   input  wire                                      rst_n,
   input  wire                                      shift_en,
   input  wire                                      cfg_bit,
   input  wire                                      commit,
   input  wire                                      clear_active,
   output lca_pkg::clb_cfg_t [`LCA_NUM_CLB-1:0]     cfg
);

   logic [`LCA_FRAME_W-1:0] shadow;
   logic [`LCA_FRAME_W-1:0] shadow_nxt;
   logic [`LCA_FRAME_W-1:0] active;

   // bits enter at the bottom, so the first one sent ends up on top
   assign shadow_nxt = {shadow[`LCA_FRAME_W-2:0], cfg_bit};

   always_ff @(posedge KLK)
   begin
      if (shift_en)
         shadow <= shadow_nxt;
   end

   always_ff @(posedge KLK or negedge rst_n)
   begin
      if (!rst_n)
      begin
         active <= '0;
      end
      else if (clear_active)
      begin
         active <= '0;
      end
      else if (commit)
      begin
         active <= shadow_nxt; // includes the bit arriving with the commit
      end
   end

   // block i sits in bits [36i+35:36i]
   assign cfg = active;

endmodule

`default_nettype wire

/* design/clb.sv */
`timescale 1ns/1ps
`default_nettype none

module clb (
   input  wire               KLK,
   input  wire               rst_n,
   input  lca_pkg::clb_cfg_t cfg,
   input  lca_pkg::clb_pins_t pins,
   input  wire               d,
   input  wire               run,
   input  wire               clr_q,
   output logic              x,
   output logic              y
);

   logic q;
   logic dq1, dq2;
   logic f, g;
   logic p_f, q_f, r_f;
   logic p_g, q_g, r_g;
   logic s, r, ce;

   assign dq1 = cfg.dq_sel[0] ? q : d;
   assign dq2 = cfg.dq_sel[1] ? q : d;

   // input muxes for the two 3-input functions
   assign p_f = cfg.in_sel_f[2] ? pins.b : pins.a;
   assign q_f = cfg.in_sel_f[1] ? pins.c : pins.b;
   assign r_f = cfg.in_sel_f[0] ? dq1    : pins.c;
   assign p_g = cfg.in_sel_g[2] ? pins.b : pins.a;
   assign q_g = cfg.in_sel_g[1] ? pins.c : pins.b;
   assign r_g = cfg.in_sel_g[0] ? dq2    : pins.c;

   always_comb
   begin
      case (cfg.mode)
         lca_pkg::MODE_ONE4:
         begin
            f = cfg.lut[{pins.a, pins.b, pins.c, dq1}];
            g = f;
         end
         lca_pkg::MODE_TWO3:
         begin
            f = cfg.lut[{1'b0, p_f, q_f, r_f}]; // lower half of the table
            g = cfg.lut[{1'b1, p_g, q_g, r_g}];
         end
         default:
         begin
            // mode 3 lands here as well
            if (pins.b)
               f = cfg.lut[{1'b1, pins.a, pins.c, dq2}];
            else
               f = cfg.lut[{1'b0, pins.a, pins.c, dq1}];
            g = f;
         end
      endcase
   end

   assign s  = (cfg.s_sel == 2'd0) ? pins.a : (cfg.s_sel == 2'd1) ? f : 1'b0;
   assign r  = (cfg.r_sel == 2'd0) ? d      : (cfg.r_sel == 2'd1) ? g : 1'b0;
   assign ce = (cfg.ce_sel == 2'd0) ? 1'b1  : (cfg.ce_sel == 2'd1) ? pins.c : pins.k;

   always_ff @(posedge KLK or negedge rst_n)
   begin
      if (!rst_n)
      begin
         q <= 1'b0;
      end
      else if (clr_q)
      begin
         q <= 1'b0;
      end
      else if (run && ce)
      begin
         if (r)
            q <= 1'b0; // reset beats set
         else if (s)
            q <= 1'b1;
         else
            q <= f;
      end
   end

   assign x = (cfg.x_sel == 2'd0) ? f : (cfg.x_sel == 2'd1) ? g : q;
   assign y = (cfg.y_sel == 2'd0) ? q : (cfg.y_sel == 2'd1) ? g : f;

endmodule

`default_nettype wire

/* design/lca_top.sv */
`timescale 1ns/1ps
`default_nettype none
`include "lca_macros.svh"

module lca_top (
   input  wire                          KLK,
   input  wire                          rst_n,
   input  wire                          cfg_start,
   input  wire                          cfg_strobe,
   input  wire                          cfg_bit,
   output logic                         cfg_done,
   input  wire  [3*`LCA_NUM_CLB-1:0]    usr_abc,
   input  wire                          usr_d,
   input  wire                          usr_k,
   output logic [2*`LCA_NUM_CLB-1:0]    usr_out
);

   logic clr_cnt, shift_en, commit, clear_active, cnt_last;

   lca_pkg::clb_cfg_t  [`LCA_NUM_CLB-1:0] active_cfg;
   lca_pkg::clb_pins_t [`LCA_NUM_CLB-1:0] clb_pins;
   logic [`LCA_NUM_CLB-1:0] clb_d;
   logic [`LCA_NUM_CLB-1:0] clb_x;
   logic [`LCA_NUM_CLB-1:0] clb_y;

   cfg_loader_fsm i_loader (
      .KLK          (KLK),
      .rst_n        (rst_n),
      .cfg_start    (cfg_start),
      .cfg_strobe   (cfg_strobe),
      .cnt_last     (cnt_last),
      .clr_cnt      (clr_cnt),
      .shift_en     (shift_en),
      .commit       (commit),
      .clear_active (clear_active),
      .cfg_done     (cfg_done)
   );

   cfg_bit_counter i_counter (
      .KLK      (KLK),
      .rst_n    (rst_n),
      .clr_cnt  (clr_cnt),
      .shift_en (shift_en),
      .cnt_last (cnt_last)
   );

   cfg_frame i_frame (
      .KLK          (KLK),
      .rst_n        (rst_n),
      .shift_en     (shift_en),
      .cfg_bit      (cfg_bit),
      .commit       (commit),
      .clear_active (clear_active),
      .cfg          (active_cfg)
   );

   for (genvar i = 0; i < `LCA_NUM_CLB; i++)
   begin : g_clb
      // a is the top bit of each group of three
      assign clb_pins[i] = '{a: usr_abc[3*i+2], b: usr_abc[3*i+1], c: usr_abc[3*i], k: usr_k};

      if (i == 0)
      begin : g_head
         assign clb_d[i] = usr_d;
      end
      else
      begin : g_chain
         assign clb_d[i] = clb_x[i-1]; // x of the previous block feeds d
      end

      clb i_clb (
         .KLK   (KLK),
         .rst_n (rst_n),
         .cfg   (active_cfg[i]),
         .pins  (clb_pins[i]),
         .d     (clb_d[i]),
         .run   (cfg_done),
         .clr_q (clear_active),
         .x     (clb_x[i]),
         .y     (clb_y[i])
      );

      assign usr_out[2*i]   = clb_x[i];
      assign usr_out[2*i+1] = clb_y[i];
   end

endmodule

`default_nettype wire

/* tb/lca_sva.sv */
`timescale 1ns/1ps
`default_nettype none
`include "lca_macros.svh"

module lca_sva (
   input wire                        KLK,
   input wire                        rst_n,
   input wire                        cfg_start,
   input wire                        commit,
   input wire                        cfg_done,
   input wire [2*`LCA_NUM_CLB-1:0]   usr_out
);

   int unsigned fail_cnt = 0; // read by the testbench

   // done rises exactly one cycle after the final strobe
   a_done_after_commit: assert property (@(posedge KLK) disable iff (!rst_n)
      commit |=> cfg_done)
      else begin fail_cnt++; $error("cfg_done did not follow the final strobe"); end

   a_done_only_from_commit: assert property (@(posedge KLK) disable iff (!rst_n)
      $rose(cfg_done) |-> $past(commit))
      else begin fail_cnt++; $error("cfg_done rose without a final strobe"); end

   a_start_clears_done: assert property (@(posedge KLK) disable iff (!rst_n)
      cfg_start |=> !cfg_done)
      else begin fail_cnt++; $error("cfg_done still high after cfg_start"); end

   // once loaded only a new start takes the array down
   a_done_holds: assert property (@(posedge KLK) disable iff (!rst_n)
      cfg_done && !cfg_start |=> cfg_done)
      else begin fail_cnt++; $error("cfg_done dropped without cfg_start"); end

   a_idle_outputs: assert property (@(posedge KLK) disable iff (!rst_n)
      !cfg_done |-> (usr_out == '0))
      else begin fail_cnt++; $error("usr_out not zero while unconfigured"); end

endmodule

`default_nettype wire

/* tb/lca_clock_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module lca_clock_gen #(
   parameter int PERIOD_NS    = 10,
   parameter int RESET_CYCLES = 10
) (
   output logic KLK,
   output logic rst_n
);

   initial
   begin
      KLK = 1'b0;
      forever #(PERIOD_NS / 2) KLK = ~KLK;
   end

   // release on a falling edge so it never races the rising edge
   initial
   begin
      rst_n = 1'b0;
      repeat (RESET_CYCLES) @(posedge KLK);
      @(negedge KLK);
      rst_n = 1'b1;
   end

endmodule

`default_nettype wire

/* tb/lca_tb.sv */
`timescale 1ns/1ps
`default_nettype none
`include "lca_macros.svh"

module lca_tb;

   localparam int ABC_W       = 3 * `LCA_NUM_CLB;
   localparam int OUT_W       = 2 * `LCA_NUM_CLB;
   localparam int NUM_LOADS   = 9;
   localparam int KIND_RANDOM = 0;
   localparam int KIND_COMB   = 1;
   localparam int KIND_STORE  = 2;
   // a strobe with its idle gap takes at most three cycles
   localparam int WATCHDOG_CYCLES = NUM_LOADS * `LCA_FRAME_W * 20 + 2000;

   logic KLK;
   logic rst_n;
   logic cfg_start = 1'b0;
   logic cfg_strobe = 1'b0;
   logic cfg_bit = 1'b0;
   logic cfg_done;
   logic [ABC_W-1:0] usr_abc = '0;
   logic usr_d = 1'b0;
   logic usr_k = 1'b0;
   logic [OUT_W-1:0] usr_out;

   logic [ABC_W-1:0] pin_mask = '1;
   string test_name = "reset";
   logic [`LCA_FRAME_W-1:0] frame_sent = '0;

   // reference model state
   logic [`LCA_FRAME_W-1:0] m_active = '0;
   logic [`LCA_NUM_CLB-1:0] m_q = '0;
   logic m_done = 1'b0;
   logic m_shift = 1'b0;
   int m_cnt = 0;

   lca_clock_gen i_clock_gen (
      .KLK   (KLK),
      .rst_n (rst_n)
   );

   lca_top i_lca_top (
      .KLK        (KLK),
      .rst_n      (rst_n),
      .cfg_start  (cfg_start),
      .cfg_strobe (cfg_strobe),
      .cfg_bit    (cfg_bit),
      .cfg_done   (cfg_done),
      .usr_abc    (usr_abc),
      .usr_d      (usr_d),
      .usr_k      (usr_k),
      .usr_out    (usr_out)
   );

   bind lca_top lca_sva i_sva (
      .KLK       (KLK),
      .rst_n     (rst_n),
      .cfg_start (cfg_start),
      .commit    (commit),
      .cfg_done  (cfg_done),
      .usr_out   (usr_out)
   );

   function automatic logic pick3(input logic [1:0] sel, input logic v0, input logic v1,
                                  input logic v2);
      return (sel == 2'd0) ? v0 : (sel == 2'd1) ? v1 : v2; // 3 acts like 2
   endfunction

   // returns {F, G} for one block
   function automatic logic [1:0] lut_fg(input lca_pkg::clb_cfg_t c, input logic [2:0] abc,
                                         input logic d, input logic q);
      logic a, b, cp, dq1, dq2;
      logic [3:0] idx_f, idx_g;
      a = abc[2];
      b = abc[1];
      cp = abc[0];
      dq1 = c.dq_sel[0] ? q : d;
      dq2 = c.dq_sel[1] ? q : d;
      if (c.mode == lca_pkg::MODE_ONE4)
      begin
         idx_f = {a, b, cp, dq1};
         idx_g = idx_f;
      end
      else if (c.mode == lca_pkg::MODE_TWO3)
      begin
         idx_f = {1'b0, c.in_sel_f[2] ? b : a, c.in_sel_f[1] ? cp : b, c.in_sel_f[0] ? dq1 : cp};
         idx_g = {1'b1, c.in_sel_g[2] ? b : a, c.in_sel_g[1] ? cp : b, c.in_sel_g[0] ? dq2 : cp};
      end
      else
      begin
         idx_f = b ? {1'b1, a, cp, dq2} : {1'b0, a, cp, dq1};
         idx_g = idx_f;
      end
      return {c.lut[idx_f], c.lut[idx_g]};
   endfunction

   task automatic model_eval(output logic [OUT_W-1:0] out, output logic [`LCA_NUM_CLB-1:0] q_nxt);
      logic [`LCA_FRAME_W-1:0] act;
      logic [ABC_W-1:0] abc;
      logic [`LCA_NUM_CLB-1:0] qv;
      lca_pkg::clb_cfg_t c;
      logic [1:0] fg;
      logic d, q, x, y, s, r, ce;
      act = m_active;
      abc = usr_abc;
      qv = m_q;
      d = usr_d;
      out = '0;
      q_nxt = '0;
      for (int i = 0; i < `LCA_NUM_CLB; i++)
      begin
         c = lca_pkg::clb_cfg_t'(act[`LCA_CLB_CFG_W-1:0]);
         q = qv[0];
         fg = lut_fg(c, abc[2:0], d, q);
         x = pick3(c.x_sel, fg[1], fg[0], q);
         y = pick3(c.y_sel, q, fg[0], fg[1]);
         s = pick3(c.s_sel, abc[2], fg[1], 1'b0);
         r = pick3(c.r_sel, d, fg[0], 1'b0);
         ce = pick3(c.ce_sel, 1'b1, abc[0], usr_k);
         // reset wins over set, set over the F function
         q_nxt = {(ce ? (r ? 1'b0 : (s ? 1'b1 : fg[1])) : q), q_nxt[`LCA_NUM_CLB-1:1]};
         out = {y, x, out[OUT_W-1:2]};
         d = x;
         act = act >> `LCA_CLB_CFG_W;
         abc = abc >> 3;
         qv = qv >> 1;
      end
   endtask

   always @(posedge KLK or negedge rst_n)
   begin
      logic [OUT_W-1:0] out_now;
      logic [`LCA_NUM_CLB-1:0] q_next;
      if (!rst_n)
      begin
         m_active = '0;
         m_q = '0;
         m_done = 1'b0;
         m_shift = 1'b0;
         m_cnt = 0;
      end
      else
      begin
         model_eval(out_now, q_next);
         if (cfg_start)
         begin
            m_active = '0;
            m_q = '0;
            m_done = 1'b0;
            m_shift = 1'b1;
            m_cnt = 0;
         end
         else
         begin
            if (m_done)
               m_q = q_next;
            if (cfg_strobe && m_shift)
            begin
               m_cnt = m_cnt + 1;
               if (m_cnt == `LCA_FRAME_W)
               begin
                  m_active = frame_sent;
                  m_done = 1'b1;
                  m_shift = 1'b0;
               end
            end
         end
      end
   end

   task automatic abort_run();
      $display("Some tests failed");
      $fatal(1);
   endtask

   task automatic report_mismatch(input string what, input logic [OUT_W-1:0] exp_val,
                                  input logic [OUT_W-1:0] act_val);
      $display("mismatch in %s: %s expected %02h actual %02h", test_name, what, exp_val, act_val);
      abort_run();
   endtask

   task automatic cycle_check();
      logic [OUT_W-1:0] exp_out;
      logic [`LCA_NUM_CLB-1:0] q_unused;
      #1;
      model_eval(exp_out, q_unused);
      assert (usr_out === exp_out)
         else report_mismatch("usr_out", exp_out, usr_out);
      assert (cfg_done === m_done)
         else report_mismatch("cfg_done", {{(OUT_W-1){1'b0}}, m_done},
                              {{(OUT_W-1){1'b0}}, cfg_done});
   endtask

   task automatic drive_random(input logic start, input logic strobe, input logic bit_val);
      @(negedge KLK);
      cfg_start = start;
      cfg_strobe = strobe;
      cfg_bit = bit_val;
      usr_abc = ABC_W'($urandom()) & pin_mask;
      usr_d = 1'($urandom());
      usr_k = 1'($urandom());
      cycle_check();
   endtask

   task automatic run_pins(input int n);
      repeat (n) drive_random(1'b0, 1'b0, 1'b0);
   endtask

   task automatic load_frame(input logic [`LCA_FRAME_W-1:0] frame);
      logic [`LCA_FRAME_W-1:0] bits;
      bits = frame;
      frame_sent = frame;
      drive_random(1'b1, 1'b0, 1'b0);
      for (int j = 0; j < `LCA_FRAME_W; j++)
      begin
         repeat ($urandom_range(2)) drive_random(1'b0, 1'b0, 1'b0);
         drive_random(1'b0, 1'b1, bits[`LCA_FRAME_W-1]); // msb first
         bits = bits << 1;
      end
      drive_random(1'b0, 1'b0, 1'b0);
      assert (cfg_done === 1'b1)
         else report_mismatch("cfg_done after load", OUT_W'(1), OUT_W'(cfg_done));
   endtask

   function automatic logic [`LCA_FRAME_W-1:0] build_frame(input int kind, input int sel);
      logic [`LCA_FRAME_W-1:0] f;
      lca_pkg::clb_cfg_t c;
      f = '0;
      for (int blk = `LCA_NUM_CLB - 1; blk >= 0; blk--)
      begin
         c = lca_pkg::clb_cfg_t'({$urandom(), 4'($urandom())});
         if (kind == KIND_COMB)
         begin
            c.mode = lca_pkg::comb_mode_e'(2'(sel));
            c.ce_sel = 2'd1; // pin c is masked low, so q never loads
            c.x_sel = 2'(blk);
            c.y_sel = 2'(3 - blk);
         end
         else if (kind == KIND_STORE)
         begin
            c.ce_sel = 2'(sel);
            c.x_sel = 2'd2;
            c.y_sel = 2'd0;
            c.s_sel = (blk == 2) ? 2'd2 : (blk == 1) ? 2'd1 : 2'd0;
            c.r_sel = c.s_sel;
         end
         f = {f[`LCA_FRAME_W-`LCA_CLB_CFG_W-1:0], c};
      end
      return f;
   endfunction

   initial
   begin
      repeat (WATCHDOG_CYCLES) @(posedge KLK);
      $display("error: run timed out after %0d clock cycles", WATCHDOG_CYCLES);
      abort_run();
   end

   always @(negedge KLK)
   begin
      if (i_lca_top.i_sva.fail_cnt != 0)
      begin
         $display("error: a bound assertion on the loader or outputs failed");
         abort_run();
      end
   end

   initial
   begin
      void'($urandom(32'h3b1d));
      @(posedge rst_n);
      run_pins(5);
      repeat (4) drive_random(1'b0, 1'b1, 1'b1); // no start, so nothing loads
      run_pins(3);

      test_name = "config_load";
      load_frame(build_frame(KIND_RANDOM, 0));
      repeat (6) drive_random(1'b0, 1'b1, 1'($urandom()));
      run_pins(20);

      test_name = "comb_modes";
      pin_mask = 12'b110_110_110_110;
      for (int m = 0; m < 3; m++)
      begin
         load_frame(build_frame(KIND_COMB, m));
         run_pins(40);
      end
      pin_mask = '1;

      test_name = "storage";
      for (int ce = 0; ce < 3; ce++)
      begin
         load_frame(build_frame(KIND_STORE, ce));
         run_pins(60);
      end
      load_frame(build_frame(KIND_RANDOM, 0));
      run_pins(60);

      test_name = "reconfig";
      drive_random(1'b1, 1'b0, 1'b0);
      run_pins(3);
      load_frame(build_frame(KIND_RANDOM, 0));
      run_pins(40);

      if (i_lca_top.i_sva.fail_cnt == 0)
      begin
         $display("All tests passed");
         $finish;
      end
      else
      begin
         $display("error: %0d bound assertion failures", i_lca_top.i_sva.fail_cnt);
         abort_run();
      end
   end

endmodule

`default_nettype wire

/* build.f */
+incdir+include
design/lca_pkg.sv
design/cfg_loader_fsm.sv
design/cfg_bit_counter.sv
design/cfg_frame.sv
design/clb.sv
design/lca_top.sv
tb/lca_sva.sv
tb/lca_clock_gen.sv
tb/lca_tb.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        ?= lca_tb
FILELIST   ?= build.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only -Wall --timing
PASS_MSG   ?= All tests passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
